// ==== rtl/bp_consts.svh ====
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Global history length, also the global table index width
`define BP_HIST_BITS 10

// Number of global table entries
`define BP_HIST_ENTRIES (1 << `BP_HIST_BITS)

// Word address bits used to index the local and choice tables
`define BP_LOCAL_BITS 10

// Lowest address bit used for indexing (word aligned)
`define BP_LOCAL_LSB 2

// Number of local and choice table entries
`define BP_LOCAL_ENTRIES (1 << `BP_LOCAL_BITS)

// Global and local counters start weakly not taken
`define BP_CTR_INIT 2'b01

// Choice counters start weakly preferring global
`define BP_CHOICE_INIT 2'b10

`endif

// ==== rtl/bpPkg.sv ====
`default_nettype none

package bpPkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_OTHER  = 6'b000000, // Anything that is not a conditional branch
        OP_REGIMM = 6'b000001,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111
    } opcodeE;

    // rt field of REGIMM, instr[20:16]
    typedef enum logic [4:0] {
        RT_BLTZ   = 5'b00000,
        RT_BGEZ   = 5'b00001,
        RT_BLTZAL = 5'b10000,
        RT_BGEZAL = 5'b10001
    } regimmE;

    typedef logic [1:0] counterT; // MSB is the predicted direction

    // Saturating step toward 3 when up is set, toward 0 otherwise
    function automatic counterT ctrNext(counterT ctr, logic up);
        counterT result;
        if (up) begin
            result = (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end else begin
            result = (ctr == 2'b00) ? ctr : ctr - 2'd1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/bpIf.sv ====
`timescale 1ns/10ps
`default_nettype none

interface bpIf;

    logic [31:0] lookupPc;          // Address of the instruction being predicted
    logic [31:0] resolvePc;         // Address of the branch being resolved
    logic        updateValid;       // One cycle training strobe
    logic        resolveTaken;      // Actual outcome
    logic        globalCorrect;
    logic        localCorrect;
    logic        flush;
    logic        globalPred;
    logic        localPred;
    logic        useGlobal;         // Chooser selects the global component
    logic        globalResolvePred;
    logic        localResolvePred;

    modport ctrl (
        output lookupPc, resolvePc, updateValid, resolveTaken,
        output globalCorrect, localCorrect, flush,
        input  globalPred, localPred, useGlobal, globalResolvePred, localResolvePred
    );

    // Names avoid the global and local keywords
    modport globalTable (
        input  updateValid, resolveTaken, flush,
        output globalPred, globalResolvePred
    );

    modport localTable (
        input  lookupPc, resolvePc, updateValid, resolveTaken,
        output localPred, localResolvePred
    );

    modport choice (
        input  lookupPc, resolvePc, updateValid, globalCorrect, localCorrect,
        output useGlobal
    );

endinterface

`default_nettype wire

// ==== rtl/predictorCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module predictorCtrl (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        FLUSH,
    input  wire logic        instrValid,
    input  wire logic [31:0] instr,
    input  wire logic [31:0] instrAddr,
    input  wire logic        resolveValid,
    input  wire logic [31:0] resolvePc,
    input  wire logic        resolveTaken,
    output logic             taken,
    bpIf.ctrl                bus
);

    bpPkg::opcodeE opcode;
    logic          isBranch;
    logic          predNext;

    // Collapse every non-branch opcode onto OTHER
    always_comb begin
        case (instr[31:26])
            bpPkg::OP_REGIMM,
            bpPkg::OP_BEQ,
            bpPkg::OP_BNE,
            bpPkg::OP_BLEZ,
            bpPkg::OP_BGTZ: opcode = bpPkg::opcodeE'(instr[31:26]);
            default:        opcode = bpPkg::OP_OTHER;
        endcase
    end

    always_comb begin
        case (opcode)
            bpPkg::OP_REGIMM: begin
                case (instr[20:16]) // Only the four REGIMM branches count
                    bpPkg::RT_BLTZ,
                    bpPkg::RT_BGEZ,
                    bpPkg::RT_BLTZAL,
                    bpPkg::RT_BGEZAL: isBranch = 1'b1;
                    default:          isBranch = 1'b0;
                endcase
            end
            bpPkg::OP_BEQ,
            bpPkg::OP_BNE,
            bpPkg::OP_BLEZ,
            bpPkg::OP_BGTZ: isBranch = 1'b1;
            default:        isBranch = 1'b0;
        endcase
    end

    assign predNext = isBranch & (bus.useGlobal ? bus.globalPred : bus.localPred);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            taken <= 1'b0;
        end else if (FLUSH) begin
            taken <= 1'b0;
        end else if (instrValid) begin
            taken <= predNext; // Held until the next lookup
        end
    end

    // Update path is purely combinational, tables write on this edge
    assign bus.lookupPc      = instrAddr;
    assign bus.resolvePc     = resolvePc;
    assign bus.updateValid   = resolveValid;
    assign bus.resolveTaken  = resolveTaken;
    assign bus.flush         = FLUSH;
    assign bus.globalCorrect = (bus.globalResolvePred == resolveTaken);
    assign bus.localCorrect  = (bus.localResolvePred == resolveTaken);

endmodule

`default_nettype wire

// ==== rtl/globalPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module globalPredictor (
    input  wire logic CLK,
    input  wire logic RESET,
    bpIf.globalTable  bus
);

    logic [`BP_HIST_BITS-1:0] history; // Most recent outcome in bit 0
    bpPkg::counterT           pht [`BP_HIST_ENTRIES];

    // Both reads follow the current history
    assign bus.globalPred        = pht[history][1];
    assign bus.globalResolvePred = pht[history][1];

    // Counter training
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_HIST_ENTRIES; i++) begin
                pht[i] <= `BP_CTR_INIT;
            end
        end else if (bus.updateValid) begin
            pht[history] <= bpPkg::ctrNext(pht[history], bus.resolveTaken);
        end
    end

    // Flush wins over the shift, training above still happens
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            history <= '0;
        end else if (bus.flush) begin
            history <= '0;
        end else if (bus.updateValid) begin
            history <= {history[`BP_HIST_BITS-2:0], bus.resolveTaken};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/localPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module localPredictor (
    input  wire logic CLK,
    input  wire logic RESET,
    bpIf.localTable   bus
);

    logic [`BP_LOCAL_BITS-1:0] lookupIdx;
    logic [`BP_LOCAL_BITS-1:0] resolveIdx;
    bpPkg::counterT            counters [`BP_LOCAL_ENTRIES];

    // Word address bits, byte offset dropped
    assign lookupIdx  = bus.lookupPc[`BP_LOCAL_BITS+`BP_LOCAL_LSB-1:`BP_LOCAL_LSB];
    assign resolveIdx = bus.resolvePc[`BP_LOCAL_BITS+`BP_LOCAL_LSB-1:`BP_LOCAL_LSB];

    assign bus.localPred        = counters[lookupIdx][1];
    assign bus.localResolvePred = counters[resolveIdx][1]; // Graded at resolve

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_LOCAL_ENTRIES; i++) begin
                counters[i] <= `BP_CTR_INIT;
            end
        end else if (bus.updateValid) begin
            counters[resolveIdx] <= bpPkg::ctrNext(counters[resolveIdx], bus.resolveTaken);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/choicePredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module choicePredictor (
    input  wire logic CLK,
    input  wire logic RESET,
    bpIf.choice       bus
);

    logic [`BP_LOCAL_BITS-1:0] lookupIdx;
    logic [`BP_LOCAL_BITS-1:0] resolveIdx;
    logic                      disagree;
    bpPkg::counterT            chooser [`BP_LOCAL_ENTRIES];

    assign lookupIdx  = bus.lookupPc[`BP_LOCAL_BITS+`BP_LOCAL_LSB-1:`BP_LOCAL_LSB];
    assign resolveIdx = bus.resolvePc[`BP_LOCAL_BITS+`BP_LOCAL_LSB-1:`BP_LOCAL_LSB];

    // Only train when exactly one component was right
    assign disagree = bus.globalCorrect ^ bus.localCorrect;

    assign bus.useGlobal = chooser[lookupIdx][1]; // High half favours global

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BP_LOCAL_ENTRIES; i++) begin
                chooser[i] <= `BP_CHOICE_INIT;
            end
        end else if (bus.updateValid && disagree) begin
            // Toward 3 if global was right, toward 0 if local was
            chooser[resolveIdx] <= bpPkg::ctrNext(chooser[resolveIdx], bus.globalCorrect);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/branchPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

module branchPredictor (
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        FLUSH,
    input  wire logic        instrValid,   // Lookup strobe
    input  wire logic [31:0] instr,
    input  wire logic [31:0] instrAddr,
    input  wire logic        resolveValid, // Training strobe
    input  wire logic [31:0] resolvePc,
    input  wire logic        resolveTaken,
    output logic             taken
);

    bpIf bpBus ();

    predictorCtrl i_ctrl (
        .CLK          (CLK),
        .RESET        (RESET),
        .FLUSH        (FLUSH),
        .instrValid   (instrValid),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .resolveValid (resolveValid),
        .resolvePc    (resolvePc),
        .resolveTaken (resolveTaken),
        .taken        (taken),
        .bus          (bpBus.ctrl)
    );

    globalPredictor i_global (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bpBus.globalTable)
    );

    localPredictor i_local (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bpBus.localTable)
    );

    // Picks which component drives the final prediction
    choicePredictor i_choice (
        .CLK   (CLK),
        .RESET (RESET),
        .bus   (bpBus.choice)
    );

endmodule

`default_nettype wire

// ==== bench/bp_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module bp_chk (
    input wire logic CLK,
    input wire logic RESET,
    input wire logic FLUSH,
    input wire logic instrValid,
    input wire logic taken
);

    int failCount = 0; // Read by the testbench at the end of the run

    // Second reset edge onward, the async clear has landed
    resetLow: assert property (@(posedge CLK) (!RESET && $past(!RESET)) |-> !taken)
        else begin
            failCount = failCount + 1;
            $error("taken is high while RESET is held low");
        end

    flushClears: assert property (@(posedge CLK) disable iff (!RESET) FLUSH |=> !taken)
        else begin
            failCount = failCount + 1;
            $error("taken is high in the cycle after FLUSH");
        end

    riseAfterLookup: assert property (@(posedge CLK) disable iff (!RESET)
        $rose(taken) |-> $past(instrValid))
        else begin
            failCount = failCount + 1;
            $error("taken rose without a lookup on the previous edge");
        end

    noUnknown: assert property (@(posedge CLK) disable iff (!RESET) !$isunknown(taken))
        else begin
            failCount = failCount + 1;
            $error("taken is unknown after reset");
        end

endmodule

bind branchPredictor bp_chk i_chk (
    .CLK        (CLK),
    .RESET      (RESET),
    .FLUSH      (FLUSH),
    .instrValid (instrValid),
    .taken      (taken)
);

`default_nettype wire

// ==== bench/tb_branchPredictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module tb_branchPredictor;

    localparam int TOTAL_CYCLES  = 3 + 16 + 24 + 32 + 40 + 6 + 400;
    localparam int MARGIN_CYCLES = 100;

    logic        CLK;
    logic        RESET;
    logic        FLUSH;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] instrAddr;
    logic        resolveValid;
    logic [31:0] resolvePc;
    logic        resolveTaken;
    logic        taken;

    logic [31:0]              rngState = 32'd57;
    logic [1:0]               gModel [`BP_HIST_ENTRIES];  // Reference tables
    logic [1:0]               lModel [`BP_LOCAL_ENTRIES];
    logic [1:0]               cModel [`BP_LOCAL_ENTRIES];
    logic [`BP_HIST_BITS-1:0] histModel;
    logic                     expTaken;
    int                       errors = 0;
    int                       checks = 0;

    branchPredictor i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [1:0] satStep(input logic [1:0] ctr, input logic up);
        int v;
        v = up ? int'(ctr) + 1 : int'(ctr) - 1;
        v = (v > 3) ? 3 : ((v < 0) ? 0 : v);
        return v[1:0];
    endfunction

    // MIPS conditional branch: REGIMM rt 0/1/16/17, or opcode 4..7
    function automatic logic isBranchInstr(input logic [31:0] ins);
        logic [4:0] rt;
        rt = ins[20:16];
        if (ins[31:26] == 6'd1) begin
            return rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17;
        end
        return ins[31:26] >= 6'd4 && ins[31:26] <= 6'd7;
    endfunction

    function automatic logic [31:0] branchForm(input logic [2:0] k, input logic [31:0] r);
        if (!k[2]) begin
            return {6'd1, r[25:21], k[1], 3'b000, k[0], r[15:0]}; // REGIMM rt form
        end
        return {3'b000, k, r[25:0]};
    endfunction

    function automatic logic [31:0] nonBranch(input logic [31:0] r);
        logic [5:0] op;
        logic [4:0] rt;
        op = r[31:26];
        rt = r[20:16];
        if (rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17) rt = 5'd2;
        if (r[0]) return {6'd1, r[25:21], rt, r[15:0]}; // REGIMM, not a branch
        if (op == 6'd1 || (op >= 6'd4 && op <= 6'd7)) op = 6'h23;
        return {op, r[25:0]};
    endfunction

    task automatic checkBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One cycle from falling edge to falling edge, model steps at the rising edge
    task automatic driveCycle(input string name, input logic iv, input logic [31:0] ins,
                              input logic [31:0] addr, input logic rv,
                              input logic [31:0] rpc, input logic rt, input logic fl);
        logic                      pred;
        logic                      gOk;
        logic                      lOk;
        logic [`BP_LOCAL_BITS-1:0] li;
        logic [`BP_LOCAL_BITS-1:0] ri;
        instrValid   = iv;
        instr        = ins;
        instrAddr    = addr;
        resolveValid = rv;
        resolvePc    = rpc;
        resolveTaken = rt;
        FLUSH        = fl;
        li = addr[`BP_LOCAL_BITS+1:2];
        ri = rpc[`BP_LOCAL_BITS+1:2];
        pred = isBranchInstr(ins) && (cModel[li][1] ? gModel[histModel][1] : lModel[li][1]);
        @(posedge CLK);
        if (fl) expTaken = 1'b0;
        else if (iv) expTaken = pred;
        if (rv) begin
            gOk = (gModel[histModel][1] == rt); // Graded before training
            lOk = (lModel[ri][1] == rt);
            gModel[histModel] = satStep(gModel[histModel], rt);
            lModel[ri] = satStep(lModel[ri], rt);
            if (gOk != lOk) cModel[ri] = satStep(cModel[ri], gOk);
        end
        if (fl) histModel = '0;
        else if (rv) histModel = {histModel[`BP_HIST_BITS-2:0], rt};
        @(negedge CLK);
        checkBit(name, expTaken, taken);
    endtask

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * 100);
        $display("Watchdog expired before the test sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] addrA;
        logic [31:0] addrB;
        logic [31:0] addrG;
        {RESET, FLUSH, instrValid, resolveValid, resolveTaken} = '0;
        {instr, instrAddr, resolvePc} = '0;
        addrA = 32'h0040_1000;
        addrB = 32'h0040_2040;
        addrG = 32'h0040_3080;
        foreach (gModel[i]) gModel[i] = `BP_CTR_INIT;
        foreach (lModel[i]) lModel[i] = `BP_CTR_INIT;
        foreach (cModel[i]) cModel[i] = `BP_CHOICE_INIT;
        histModel = '0;
        expTaken = 1'b0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;
        for (int i = 0; i < 16; i++) begin // Cold tables never predict taken
            r = nextRand();
            driveCycle("cold", 1'b1, branchForm(i[2:0], r), r & ~32'd3, 1'b0, '0, 1'b0, 1'b0);
            checkBit("cold", 1'b0, taken);
        end
        for (int i = 0; i < 24; i++) begin // Untrained chooser at addrG keeps global
            r = nextRand();
            driveCycle("global", 1'b1, branchForm(3'd4, r), addrG, 1'b1, addrA, 1'b1, 1'b0);
        end
        for (int i = 0; i < 16; i++) begin // Non-branch then branch, so taken toggles
            r = nextRand();
            driveCycle("decode", 1'b1, nonBranch(r), addrA, 1'b0, '0, 1'b0, 1'b0);
            driveCycle("decode", 1'b1, branchForm(i[2:0], r), addrA, 1'b0, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin // Noise resolves scramble the history
            r = nextRand();
            driveCycle("local", 1'b1, branchForm(3'd1, r), addrB, 1'b1, addrB, 1'b1, 1'b0);
            driveCycle("local", 1'b1, branchForm(3'd5, r), addrB, 1'b1, r & ~32'd3, r[3], 1'b0);
        end
        r = nextRand();
        driveCycle("flush", 1'b1, branchForm(3'd2, r), addrA, 1'b1, addrA, 1'b1, 1'b1);
        for (int i = 0; i < 5; i++) begin // Global entry at history zero via addrG
            r = nextRand();
            driveCycle("flush", 1'b1, branchForm(r[2:0], r), i[0] ? addrA : addrG,
                       1'b0, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < 400; i++) begin
            r  = nextRand();
            r2 = nextRand();
            driveCycle("random", r[5] | r[6], r[7] ? nonBranch(r2) : branchForm(r[10:8], r2),
                       32'h0040_0000 + {r[4:2], 2'b00}, r[11] | r[12],
                       32'h0040_0000 + {r2[4:2], 2'b00}, r2[3] ? r[13] : 1'b1,
                       r[19:14] == 6'd0);
        end
        instrValid   = 1'b0;
        resolveValid = 1'b0;
        FLUSH        = 1'b0;
        @(negedge CLK);
        $display("Checks %0d, model mismatches %0d, assertion failures %0d",
                 checks, errors, i_dut.i_chk.failCount);
        if (errors == 0 && i_dut.i_chk.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/bpPkg.sv
rtl/bpIf.sv
rtl/predictorCtrl.sv
rtl/globalPredictor.sv
rtl/localPredictor.sv
rtl/choicePredictor.sv
rtl/branchPredictor.sv
bench/bp_chk.sv
bench/tb_branchPredictor.sv

// ==== Bender.yml ====
package:
  name: branch_predictor

export_include_dirs:
  - rtl

sources:
  - rtl/bpPkg.sv
  - rtl/bpIf.sv
  - rtl/predictorCtrl.sv
  - rtl/globalPredictor.sv
  - rtl/localPredictor.sv
  - rtl/choicePredictor.sv
  - rtl/branchPredictor.sv
  - target: simulation
    files:
      - bench/bp_chk.sv
      - bench/tb_branchPredictor.sv
